/* dv/fcvt_checker.sv */
// Result checker that compares conversion unit results with the expected queue in order
`timescale 1ns/10ps
`default_nettype none

module fcvt_checker import fpu_pkg::*; (
    input wire          clk,
    input wire          rst_n_i,
    input wire          enable_i,
    input wire          valid_i,
    input wire [31:0]   result_i,
    input wire fflags_t fflags_i
);

    // Expected results with the oldest first
    logic [31:0] exp_result_q [$];
    fflags_t     exp_flags_q [$];
    string       name_q [$];

    int pass_count;
    int fail_count;
    int seen_count;

    initial begin
        pass_count = 0;
        fail_count = 0;
        seen_count = 0;
    end

    task automatic push_expected(input logic [31:0] result, input fflags_t flags,
                                 input string name);
        exp_result_q.push_back(result);
        exp_flags_q.push_back(flags);
        name_q.push_back(name);
    endtask

    // Anything still queued at the end never came out of the DUT
    task automatic check_drained();
        if (exp_result_q.size() != 0) begin
            $display("%0d expected results were never produced by the DUT, first one is %s",
                     exp_result_q.size(), name_q[0]);
            fail_count += exp_result_q.size();
        end
    endtask

    // A result is taken on an enabled edge only, a stalled one is held and seen later
    always @(posedge clk) begin : compare
        logic [31:0] want_result;
        fflags_t     want_flags;
        string       name;
        logic        ok;

        if (rst_n_i && $isunknown(valid_i)) begin
            $display("valid_o is unknown at t=%0t after reset", $time);
            fail_count++;
        end else if (rst_n_i && enable_i && valid_i) begin
            seen_count++;
            if (exp_result_q.size() == 0) begin
                $display("valid_o pulsed at t=%0t with no operand waiting for a result",
                         $time);
                fail_count++;
            end else begin
                want_result = exp_result_q.pop_front();
                want_flags  = exp_flags_q.pop_front();
                name        = name_q.pop_front();
                ok          = 1'b1;
                if (result_i !== want_result) begin
                    $display("FAILED t=%0t result_o: expected %h, got %h (%s)",
                             $time, want_result, result_i, name);
                    ok = 1'b0;
                end
                if (fflags_i !== want_flags) begin
                    $display("FAILED t=%0t fflags_o: expected %b, got %b (%s)",
                             $time, want_flags, fflags_i, name);
                    ok = 1'b0;
                end
                if (ok) begin
                    $display("passed  %-20s result_o=%h fflags_o=%b", name, result_i, fflags_i);
                    pass_count++;
                end else begin
                    fail_count++;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* dv/fcvt_unit_tb.sv */
// Testbench for the conversion unit applying a table of conversions with random enable stalls
`timescale 1ns/10ps
`default_nettype none

module fcvt_unit_tb import fpu_pkg::*; ();

    localparam int MAX_VECTORS   = 32;
    localparam int PIPE_CYCLES   = 5;
    localparam int MARGIN_CYCLES = 20;
    localparam logic [4:0] NONE  = 5'b00000;
    localparam logic [4:0] NV    = 5'b10000;
    localparam logic [4:0] NX    = 5'b00001;

    logic         clk;
    logic         rst_n_i;
    logic         enable_i;
    logic         valid_i;
    logic         is_itof_i;
    logic         is_signed_i;
    rnd_mode_e    frm_i;
    logic [31:0]  dataa_i;
    wire          valid_o;
    wire  [31:0]  result_o;
    fflags_t      fflags_o;

    // Stimulus table and expected values
    logic         tab_itof [MAX_VECTORS];
    logic         tab_signed [MAX_VECTORS];
    rnd_mode_e    tab_frm [MAX_VECTORS];
    logic [31:0]  tab_operand [MAX_VECTORS];
    logic [31:0]  tab_result [MAX_VECTORS];
    logic [4:0]   tab_flags [MAX_VECTORS];
    string        tab_name [MAX_VECTORS];
    int           tab_stall [MAX_VECTORS];
    int           num_vectors;
    int           total_stalls;
    logic [31:0]  rand_state;
    int           cycle_count;
    int           cycle_limit;
    logic         limit_armed;

    fcvt_unit #(
        .LATENCY (4),
        .OUT_REG (1)
    ) fcvt_unit_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .enable_i    (enable_i),
        .valid_i     (valid_i),
        .is_itof_i   (is_itof_i),
        .is_signed_i (is_signed_i),
        .frm_i       (frm_i),
        .dataa_i     (dataa_i),
        .valid_o     (valid_o),
        .result_o    (result_o),
        .fflags_o    (fflags_o)
    );

    fcvt_checker result_check_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .enable_i (enable_i),
        .valid_i  (valid_o),
        .result_i (result_o),
        .fflags_i (fflags_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    task automatic add_vector(input logic itof, input logic sgn, input rnd_mode_e frm,
                              input logic [31:0] operand, input logic [31:0] result,
                              input logic [4:0] flags, input string name);
        tab_itof[num_vectors]    = itof;
        tab_signed[num_vectors]  = sgn;
        tab_frm[num_vectors]     = frm;
        tab_operand[num_vectors] = operand;
        tab_result[num_vectors]  = result;
        tab_flags[num_vectors]   = flags;
        tab_name[num_vectors]    = name;
        num_vectors++;
    endtask

    task automatic build_table();
        // Integer to float with exact values
        add_vector(1, 0, RNE, 32'h0000_0000, 32'h0000_0000, NONE, "itof zero");
        add_vector(1, 1, RNE, 32'h0000_0001, 32'h3F80_0000, NONE, "itof one");
        add_vector(1, 1, RNE, 32'hFFFF_FFFF, 32'hBF80_0000, NONE, "itof minus one");
        add_vector(1, 1, RNE, 32'h8000_0000, 32'hCF00_0000, NONE, "itof int min");
        add_vector(1, 0, RNE, 32'hB2D0_5E00, 32'h4F32_D05E, NONE, "itof 3e9 unsigned");
        // 2**32-1 needs 32 bits, so it rounds up to 2**32
        add_vector(1, 0, RNE, 32'hFFFF_FFFF, 32'h4F80_0000, NX, "itof uint max");
        // 2**24+1 sits halfway between two floats
        add_vector(1, 1, RNE, 32'h0100_0001, 32'h4B80_0000, NX, "itof tie rne");
        add_vector(1, 1, RTZ, 32'h0100_0001, 32'h4B80_0000, NX, "itof tie rtz");
        add_vector(1, 1, RUP, 32'h0100_0001, 32'h4B80_0001, NX, "itof tie rup");
        add_vector(1, 1, RMM, 32'h0100_0001, 32'h4B80_0001, NX, "itof tie rmm");
        add_vector(1, 1, RDN, 32'h0100_0001, 32'h4B80_0000, NX, "itof tie rdn");
        add_vector(1, 1, RDN, 32'hFEFF_FFFF, 32'hCB80_0001, NX, "itof neg tie rdn");
        // Float to integer rounding
        add_vector(0, 1, RNE, 32'h4020_0000, 32'h0000_0002, NX, "ftoi 2.5 rne");
        add_vector(0, 1, RMM, 32'h4020_0000, 32'h0000_0003, NX, "ftoi 2.5 rmm");
        add_vector(0, 1, RTZ, 32'hBFC0_0000, 32'hFFFF_FFFF, NX, "ftoi -1.5 rtz");
        add_vector(0, 1, RDN, 32'h3F40_0000, 32'h0000_0000, NX, "ftoi 0.75 rdn");
        add_vector(0, 1, RUP, 32'h3F40_0000, 32'h0000_0001, NX, "ftoi 0.75 rup");
        add_vector(0, 1, RNE, 32'h0000_0000, 32'h0000_0000, NONE, "ftoi zero");
        add_vector(0, 1, RNE, 32'hCF00_0000, 32'h8000_0000, NONE, "ftoi int min");
        add_vector(0, 0, RNE, 32'h4F32_D05E, 32'hB2D0_5E00, NONE, "ftoi 3e9 unsigned");
        add_vector(0, 0, RTZ, 32'hBF00_0000, 32'h0000_0000, NX, "ftoi -0.5 unsigned");
        // Saturating special cases
        add_vector(0, 1, RNE, 32'h7FC0_0000, 32'h7FFF_FFFF, NV, "ftoi nan signed");
        add_vector(0, 0, RNE, 32'h7FC0_0000, 32'hFFFF_FFFF, NV, "ftoi nan unsigned");
        add_vector(0, 1, RNE, 32'h7F80_0000, 32'h7FFF_FFFF, NV, "ftoi +inf");
        add_vector(0, 1, RNE, 32'hFF80_0000, 32'h8000_0000, NV, "ftoi -inf");
        add_vector(0, 1, RNE, 32'h4F32_D05E, 32'h7FFF_FFFF, NV, "ftoi 3e9 signed");
        add_vector(0, 0, RNE, 32'hC000_0000, 32'h0000_0000, NV, "ftoi -2.0 unsigned");
    endtask

    // Run limit counted from the end of reset
    always @(posedge clk) begin
        if (limit_armed) begin
            cycle_count++;
            if (cycle_count > cycle_limit) begin
                $display("Timeout: only %0d of %0d results seen after %0d cycles",
                         result_check_i.seen_count, num_vectors, cycle_count);
                $display("RESULT: FAIL");
                $finish;
            end
        end
    end

    initial begin : stimulus
        logic [31:0] r;

        rst_n_i      = 1'b0;
        enable_i     = 1'b0;
        valid_i      = 1'b0;
        is_itof_i    = 1'b0;
        is_signed_i  = 1'b0;
        frm_i        = RNE;
        dataa_i      = '0;
        num_vectors  = 0;
        total_stalls = 0;
        cycle_count  = 0;
        limit_armed  = 1'b0;
        rand_state   = 32'h6397_48a1;

        build_table();
        for (int i = 0; i < num_vectors; i++) begin
            r = next_random();
            tab_stall[i] = (r[31:28] < 4'd5) ? 1 + int'(r[15:0] % 3) : 0;
            total_stalls += tab_stall[i];
        end
        cycle_limit = num_vectors + total_stalls + PIPE_CYCLES + MARGIN_CYCLES;

        repeat (3) @(negedge clk);
        rst_n_i     = 1'b1;
        enable_i    = 1'b1;
        limit_armed = 1'b1;

        for (int i = 0; i < num_vectors; i++) begin
            // Junk operands offered while stalled must be dropped
            for (int g = 0; g < tab_stall[i]; g++) begin
                @(negedge clk);
                r           = next_random();
                enable_i    = 1'b0;
                valid_i     = 1'b1;
                is_itof_i   = r[0];
                is_signed_i = r[1];
                dataa_i     = next_random();
            end
            @(negedge clk);
            enable_i    = 1'b1;
            valid_i     = 1'b1;
            is_itof_i   = tab_itof[i];
            is_signed_i = tab_signed[i];
            frm_i       = tab_frm[i];
            dataa_i     = tab_operand[i];
            result_check_i.push_expected(tab_result[i], fflags_t'(tab_flags[i]), tab_name[i]);
        end
        @(negedge clk);
        valid_i = 1'b0;

        while (result_check_i.seen_count < num_vectors) begin
            @(negedge clk);
        end
        // A few more cycles to catch any extra result
        repeat (4) @(negedge clk);
        result_check_i.check_drained();

        $display("Summary: %0d tests passed, %0d failed",
                 result_check_i.pass_count, result_check_i.fail_count);
        if (result_check_i.fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* fcvt_unit.f */
logic/fpu_pkg.sv
logic/fp_classifier.sv
logic/lzc.sv
logic/pipe_register.sv
logic/fp_rounding.sv
logic/fcvt_unit.sv
dv/fcvt_checker.sv
dv/fcvt_unit_tb.sv

/* logic/fcvt_unit.sv */
// Conversion unit for pipelined int-to-float and float-to-int conversion with IEEE flags
`timescale 1ns/10ps
`default_nettype none

module fcvt_unit import fpu_pkg::*; #(
    parameter int LATENCY   = 4,
    parameter int OUT_REG   = 1,
    parameter int INT_WIDTH = 32,
    parameter int EXP_BITS  = 8,
    parameter int MAN_BITS  = 23
) (
    input  wire                 clk,
    input  wire                 rst_n_i,
    input  wire                 enable_i,
    input  wire                 valid_i,
    input  wire                 is_itof_i,
    input  wire                 is_signed_i,
    input  wire rnd_mode_e      frm_i,
    input  wire [INT_WIDTH-1:0] dataa_i,
    output wire                 valid_o,
    output wire [INT_WIDTH-1:0] result_o,
    output wire fflags_t        fflags_o
);

    localparam int EXP_BIAS    = 2**(EXP_BITS-1) - 1;
    // Internal mantissa holds either hidden bit plus fraction or a whole integer
    localparam int S_MAN_WIDTH = (MAN_BITS + 1 > INT_WIDTH) ? MAN_BITS + 1 : INT_WIDTH;
    localparam int LZC_WIDTH   = $clog2(S_MAN_WIDTH);
    localparam int INT_LOG     = $clog2(INT_WIDTH);
    localparam int BIAS_LOG    = $clog2(EXP_BIAS + MAN_BITS);
    localparam int EXP_MAX     = (EXP_BITS > BIAS_LOG) ? EXP_BITS : BIAS_LOG;
    // Signed exponent wide enough for the smallest subnormal
    localparam int S_EXP_WIDTH = ((INT_LOG > EXP_MAX) ? INT_LOG : EXP_MAX) + 1;
    localparam int SHIFT_COMP  = S_MAN_WIDTH - 1 - MAN_BITS;
    localparam int DST_WIDTH   = 2 * S_MAN_WIDTH + 1;
    localparam int NUM_FP_STICKY  = 2 * S_MAN_WIDTH - MAN_BITS - 1;
    localparam int NUM_INT_STICKY = 2 * S_MAN_WIDTH - INT_WIDTH;
    localparam int FCLASS_BITS = $bits(fclass_t);

    // Operand decode

    fclass_t                fclass;
    logic                   itof_sign;
    logic                   in_sign;
    logic [S_MAN_WIDTH-1:0] itof_mant;
    logic [S_MAN_WIDTH-1:0] ftoi_mant;
    logic [S_MAN_WIDTH-1:0] in_mant;
    logic [S_EXP_WIDTH-1:0] in_exp;

    fp_classifier #(
        .EXP_BITS (EXP_BITS),
        .MAN_BITS (MAN_BITS)
    ) fp_classifier_i (
        .exp_i  (dataa_i[MAN_BITS +: EXP_BITS]),
        .man_i  (dataa_i[MAN_BITS-1:0]),
        .clss_o (fclass)
    );

    // Integer source becomes a magnitude, float source gets its hidden bit
    assign itof_sign = dataa_i[INT_WIDTH-1] & is_signed_i;
    assign itof_mant = S_MAN_WIDTH'(itof_sign ? -dataa_i : dataa_i);
    assign ftoi_mant = S_MAN_WIDTH'({fclass.is_normal, dataa_i[MAN_BITS-1:0]});
    assign in_exp    = S_EXP_WIDTH'(dataa_i[MAN_BITS +: EXP_BITS])
                     + S_EXP_WIDTH'(fclass.is_subnormal);
    assign in_mant   = is_itof_i ? itof_mant : ftoi_mant;
    assign in_sign   = is_itof_i ? itof_sign : dataa_i[INT_WIDTH-1];

    logic                   valid_s0;
    logic                   is_itof_s0;
    logic                   is_signed_s0;
    logic [2:0]             frm_s0;
    fclass_t                fclass_s0;
    logic                   sign_s0;
    logic [S_EXP_WIDTH-1:0] exp_s0;
    logic [S_MAN_WIDTH-1:0] mant_s0;

    pipe_register #(
        .DATAW (7 + FCLASS_BITS + S_EXP_WIDTH + S_MAN_WIDTH),
        .DEPTH (LATENCY > 1)
    ) pipe_reg0_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .enable_i (enable_i),
        .data_i   ({valid_i, is_itof_i, is_signed_i, frm_i, fclass, in_sign, in_exp, in_mant}),
        .data_o   ({valid_s0, is_itof_s0, is_signed_s0, frm_s0, fclass_s0, sign_s0, exp_s0,
                    mant_s0})
    );

    // Normalization

    logic [LZC_WIDTH-1:0]   shamt_s0;
    logic                   mant_nonzero_s0;
    logic [S_MAN_WIDTH-1:0] mant_n_s0;
    logic [S_EXP_WIDTH-1:0] exp_n_s0;

    lzc #(
        .N (S_MAN_WIDTH)
    ) lzc_i (
        .data_i  (mant_s0),
        .cnt_o   (shamt_s0),
        .valid_o (mant_nonzero_s0)
    );

    assign mant_n_s0 = mant_s0 << shamt_s0;

    // True exponent of the leading one after the shift
    assign exp_n_s0 = is_itof_s0
                    ? S_EXP_WIDTH'(S_MAN_WIDTH - 1) - S_EXP_WIDTH'(shamt_s0)
                    : exp_s0 + S_EXP_WIDTH'(SHIFT_COMP - EXP_BIAS) - S_EXP_WIDTH'(shamt_s0);

    logic                   valid_s1;
    logic                   is_itof_s1;
    logic                   is_signed_s1;
    logic [2:0]             frm_s1;
    fclass_t                fclass_s1;
    logic                   sign_s1;
    logic                   mant_zero_s1;
    logic [S_MAN_WIDTH-1:0] mant_s1;
    logic [S_EXP_WIDTH-1:0] exp_s1;

    pipe_register #(
        .DATAW (8 + FCLASS_BITS + S_MAN_WIDTH + S_EXP_WIDTH),
        .DEPTH (LATENCY > 2)
    ) pipe_reg1_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .enable_i (enable_i),
        .data_i   ({valid_s0, is_itof_s0, is_signed_s0, frm_s0, fclass_s0, sign_s0,
                    ~mant_nonzero_s0, mant_n_s0, exp_n_s0}),
        .data_o   ({valid_s1, is_itof_s1, is_signed_s1, frm_s1, fclass_s1, sign_s1,
                    mant_zero_s1, mant_s1, exp_s1})
    );

    // Alignment to the destination format

    logic [S_EXP_WIDTH-1:0] denorm_shamt_s1;
    logic [S_EXP_WIDTH-1:0] align_shamt_s1;
    logic                   int_min_s1;
    logic                   overflow_s1;
    logic                   underflow_s1;
    logic [DST_WIDTH-1:0]   dst_full_s1;
    logic [DST_WIDTH-1:0]   dst_mant_s1;
    logic [EXP_BITS-1:0]    final_exp_s1;
    logic                   of_before_round_s1;

    assign denorm_shamt_s1 = S_EXP_WIDTH'(INT_WIDTH - 1) - exp_s1;

    // Exactly -2**31 still fits a signed integer
    assign int_min_s1 = sign_s1 & is_signed_s1 & (denorm_shamt_s1 == '0)
                      & (mant_s1 == {1'b1, {(S_MAN_WIDTH-1){1'b0}}});

    assign overflow_s1 = is_signed_s1
                       ? (($signed(denorm_shamt_s1) <= 0) & ~int_min_s1)
                       : ($signed(denorm_shamt_s1) < 0);

    // Below one half only the sticky bit survives
    assign underflow_s1 = ($signed(exp_s1) < -1);

    always_comb begin
        if (overflow_s1) begin
            align_shamt_s1 = '0;
        end else if (underflow_s1) begin
            align_shamt_s1 = S_EXP_WIDTH'(INT_WIDTH + 1);
        end else begin
            align_shamt_s1 = denorm_shamt_s1;
        end
    end

    assign dst_full_s1        = {mant_s1, {(S_MAN_WIDTH+1){1'b0}}};
    assign dst_mant_s1        = is_itof_s1 ? dst_full_s1 : (dst_full_s1 >> align_shamt_s1);
    assign final_exp_s1       = exp_s1[EXP_BITS-1:0] + EXP_BITS'(EXP_BIAS);
    assign of_before_round_s1 = overflow_s1 & ~is_itof_s1;

    logic                 valid_s2;
    logic                 is_itof_s2;
    logic                 is_signed_s2;
    logic [2:0]           frm_s2;
    fclass_t              fclass_s2;
    logic                 mant_zero_s2;
    logic                 sign_s2;
    logic [DST_WIDTH-1:0] dst_mant_s2;
    logic [EXP_BITS-1:0]  final_exp_s2;
    logic                 of_before_round_s2;

    pipe_register #(
        .DATAW (9 + FCLASS_BITS + DST_WIDTH + EXP_BITS),
        .DEPTH (LATENCY > 0)
    ) pipe_reg2_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .enable_i (enable_i),
        .data_i   ({valid_s1, is_itof_s1, is_signed_s1, frm_s1, fclass_s1, mant_zero_s1,
                    sign_s1, dst_mant_s1, final_exp_s1, of_before_round_s1}),
        .data_o   ({valid_s2, is_itof_s2, is_signed_s2, frm_s2, fclass_s2, mant_zero_s2,
                    sign_s2, dst_mant_s2, final_exp_s2, of_before_round_s2})
    );

    // Rounding

    logic [MAN_BITS-1:0]  final_mant_s2;
    logic [INT_WIDTH-1:0] final_int_s2;
    logic [1:0]           itof_rs_s2;
    logic [1:0]           ftoi_rs_s2;
    logic [INT_WIDTH-1:0] pre_round_abs_s2;
    logic [INT_WIDTH-1:0] rounded_abs_s2;
    logic                 rounded_sign_s2;
    logic                 ftoi_of_s2;

    // Float field drops the hidden bit, integer keeps every bit
    assign final_mant_s2 = dst_mant_s2[2*S_MAN_WIDTH-1 -: MAN_BITS];
    assign itof_rs_s2    = {dst_mant_s2[2*S_MAN_WIDTH-1-MAN_BITS],
                            |dst_mant_s2[NUM_FP_STICKY-1:0]};
    assign final_int_s2  = dst_mant_s2[2*S_MAN_WIDTH -: INT_WIDTH];
    assign ftoi_rs_s2    = {dst_mant_s2[2*S_MAN_WIDTH-INT_WIDTH],
                            |dst_mant_s2[NUM_INT_STICKY-1:0]};

    // A mantissa carry simply ripples into the exponent field
    assign pre_round_abs_s2 = is_itof_s2 ? INT_WIDTH'({final_exp_s2, final_mant_s2})
                                         : final_int_s2;

    fp_rounding #(
        .DAT_WIDTH (INT_WIDTH)
    ) fp_rounding_i (
        .abs_value_i             (pre_round_abs_s2),
        .sign_i                  (sign_s2),
        .round_sticky_bits_i     (is_itof_s2 ? itof_rs_s2 : ftoi_rs_s2),
        .rnd_mode_i              (rnd_mode_e'(frm_s2)),
        .effective_subtraction_i (1'b0),
        .abs_rounded_o           (rounded_abs_s2),
        .sign_o                  (rounded_sign_s2),
        .exact_zero_o            ()
    );

    // Rounding up can still push the integer out of range
    assign ftoi_of_s2 = of_before_round_s2 | (~is_itof_s2 & (is_signed_s2
                      ? (~sign_s2 & rounded_abs_s2[INT_WIDTH-1])
                      : ((rounded_abs_s2 == '0) & (pre_round_abs_s2 != '0))));

    logic                 valid_s3;
    logic                 is_itof_s3;
    logic                 is_signed_s3;
    fclass_t              fclass_s3;
    logic                 mant_zero_s3;
    logic                 sign_s3;
    logic [INT_WIDTH-1:0] rounded_abs_s3;
    logic                 rounded_sign_s3;
    logic                 ftoi_of_s3;
    logic                 ftoi_nx_s3;
    logic                 itof_nx_s3;

    pipe_register #(
        .DATAW (9 + FCLASS_BITS + INT_WIDTH),
        .DEPTH (LATENCY > 3)
    ) pipe_reg3_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .enable_i (enable_i),
        .data_i   ({valid_s2, is_itof_s2, is_signed_s2, fclass_s2, mant_zero_s2, sign_s2,
                    rounded_abs_s2, rounded_sign_s2, ftoi_of_s2, |ftoi_rs_s2, |itof_rs_s2}),
        .data_o   ({valid_s3, is_itof_s3, is_signed_s3, fclass_s3, mant_zero_s3, sign_s3,
                    rounded_abs_s3, rounded_sign_s3, ftoi_of_s3, ftoi_nx_s3, itof_nx_s3})
    );

    // Result assembly

    logic [INT_WIDTH-1:0] fmt_result_s3;
    logic [INT_WIDTH-1:0] int_res_s3;
    logic [INT_WIDTH-1:0] special_res_s3;
    logic                 ftoi_special_s3;
    logic [INT_WIDTH-1:0] result_s3;
    fflags_t              flags_s3;

    // Integer zero has no float encoding of its own
    assign fmt_result_s3 = mant_zero_s3 ? '0
                         : INT_WIDTH'({rounded_sign_s3, rounded_abs_s3[EXP_BITS+MAN_BITS-1:0]});

    assign int_res_s3 = rounded_sign_s3 ? -rounded_abs_s3 : rounded_abs_s3;

    // Negative values saturate low, NaN and positive values saturate high
    always_comb begin
        if (sign_s3 && !fclass_s3.is_nan) begin
            special_res_s3 = {is_signed_s3, {(INT_WIDTH-1){1'b0}}};
        end else begin
            special_res_s3 = {~is_signed_s3, {(INT_WIDTH-1){1'b1}}};
        end
    end

    assign ftoi_special_s3 = fclass_s3.is_nan | fclass_s3.is_inf | ftoi_of_s3
                           | (sign_s3 & ~is_signed_s3 & (int_res_s3 != '0));

    always_comb begin
        flags_s3 = '0;
        if (is_itof_s3) begin
            result_s3   = fmt_result_s3;
            flags_s3.nx = itof_nx_s3;
        end else if (ftoi_special_s3) begin
            result_s3   = special_res_s3;
            flags_s3.nv = 1'b1;
        end else begin
            result_s3   = int_res_s3;
            flags_s3.nx = ftoi_nx_s3;
        end
    end

    pipe_register #(
        .DATAW (1 + INT_WIDTH + FP_FLAGS_BITS),
        .DEPTH (OUT_REG)
    ) pipe_reg4_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .enable_i (enable_i),
        .data_i   ({valid_s3, result_s3, flags_s3}),
        .data_o   ({valid_o, result_o, fflags_o})
    );

endmodule

`default_nettype wire

/* logic/fp_classifier.sv */
// Floating-point classifier that decodes exponent and mantissa into class flags
`timescale 1ns/10ps
`default_nettype none

module fp_classifier import fpu_pkg::*; #(
    parameter int EXP_BITS = 8,
    parameter int MAN_BITS = 23
) (
    input  wire [EXP_BITS-1:0] exp_i,
    input  wire [MAN_BITS-1:0] man_i,
    output fclass_t            clss_o
);

    logic exp_zero;
    logic exp_ones;
    logic man_zero;

    assign exp_zero = (exp_i == '0);
    assign exp_ones = (exp_i == '1);
    assign man_zero = (man_i == '0);

    always_comb begin
        clss_o.is_zero      = exp_zero & man_zero;
        clss_o.is_subnormal = exp_zero & ~man_zero;
        clss_o.is_normal    = ~exp_zero & ~exp_ones;
        clss_o.is_inf       = exp_ones & man_zero;
        clss_o.is_nan       = exp_ones & ~man_zero;
        // Quiet NaNs carry the top fraction bit set
        clss_o.is_quiet     = exp_ones & ~man_zero & man_i[MAN_BITS-1];
    end

endmodule

`default_nettype wire

/* logic/fp_rounding.sv */
// Rounding unit that applies the rounding mode to an absolute value and its sign
`timescale 1ns/10ps
`default_nettype none

module fp_rounding import fpu_pkg::*; #(
    parameter int DAT_WIDTH = 32
) (
    input  wire [DAT_WIDTH-1:0]  abs_value_i,
    input  wire                  sign_i,
    // Round bit above, collapsed sticky bit below
    input  wire [1:0]            round_sticky_bits_i,
    input  wire rnd_mode_e       rnd_mode_i,
    input  wire                  effective_subtraction_i,
    output logic [DAT_WIDTH-1:0] abs_rounded_o,
    output logic                 sign_o,
    output logic                 exact_zero_o
);

    logic round_up;
    logic any_dropped;

    assign any_dropped = |round_sticky_bits_i;

    always_comb begin
        case (rnd_mode_i)
            RNE: begin
                // Halfway cases go to the even neighbour
                round_up = round_sticky_bits_i[1] &
                           (round_sticky_bits_i[0] | abs_value_i[0]);
            end
            RTZ: begin
                round_up = 1'b0;
            end
            RDN: begin
                round_up = any_dropped & sign_i;
            end
            RUP: begin
                round_up = any_dropped & ~sign_i;
            end
            RMM: begin
                round_up = round_sticky_bits_i[1];
            end
            default: begin
                round_up = 1'b0;
            end
        endcase
    end

    assign abs_rounded_o = abs_value_i + DAT_WIDTH'(round_up);

    assign exact_zero_o = (abs_value_i == '0) && (round_sticky_bits_i == 2'b00);

    // An exact zero from a subtraction is negative only when rounding down
    assign sign_o = (exact_zero_o & effective_subtraction_i) ? (rnd_mode_i == RDN) : sign_i;

endmodule

`default_nettype wire

/* logic/fpu_pkg.sv */
// FPU shared types for rounding modes, operand class and IEEE status flags
`default_nettype none

package fpu_pkg;

    // Rounding modes in the encoding of the RISC-V frm field
    typedef enum logic [2:0] {
        // Nearest with ties to even
        RNE = 3'd0,
        // Toward zero
        RTZ = 3'd1,
        // Toward minus infinity
        RDN = 3'd2,
        // Toward plus infinity
        RUP = 3'd3,
        // Nearest with ties away from zero
        RMM = 3'd4
    } rnd_mode_e;

    // Operand class of a binary32 value
    typedef struct packed {
        logic is_zero;
        logic is_subnormal;
        logic is_normal;
        logic is_inf;
        logic is_nan;
        // Only meaningful together with is_nan
        logic is_quiet;
    } fclass_t;

    // Width of the IEEE status flag vector
    localparam int FP_FLAGS_BITS = 5;

    // IEEE status flags with the most significant first
    typedef struct packed {
        // Invalid operation
        logic nv;
        // Divide by zero
        logic dz;
        // Overflow
        logic of;
        // Underflow
        logic uf;
        // Inexact
        logic nx;
    } fflags_t;

endpackage

`default_nettype wire

/* logic/lzc.sv */
// Leading-zero counter with a nonzero indication
`timescale 1ns/10ps
`default_nettype none

module lzc #(
    parameter int N = 32
) (
    input  wire [N-1:0]                        data_i,
    output logic [((N > 1) ? $clog2(N) : 1)-1:0] cnt_o,
    output logic                               valid_o
);

    localparam int CW = (N > 1) ? $clog2(N) : 1;

    // Scan upward so the most significant set bit is the last one to win
    always_comb begin
        cnt_o = '0;
        for (int i = 0; i < N; i++) begin
            if (data_i[i]) begin
                cnt_o = CW'(N - 1 - i);
            end
        end
    end

    assign valid_o = |data_i;

endmodule

`default_nettype wire

/* logic/pipe_register.sv */
// Pipeline register with enable and clear, or a plain connection at depth zero
`timescale 1ns/10ps
`default_nettype none

module pipe_register #(
    parameter int DATAW = 8,
    parameter int DEPTH = 1
) (
    input  wire             clk,
    input  wire             rst_n_i,
    input  wire             enable_i,
    input  wire [DATAW-1:0] data_i,
    output wire [DATAW-1:0] data_o
);

    generate
        if (DEPTH == 0) begin : g_wire
            assign data_o = data_i;
        end else begin : g_flop
            logic [DATAW-1:0] data_q;

            always_ff @(posedge clk) begin
                if (!rst_n_i) begin
                    data_q <= '0;
                end else if (enable_i) begin
                    data_q <= data_i;
                end
            end

            assign data_o = data_q;
        end
    endgenerate

endmodule

`default_nettype wire
